// ==== hw/sv32_pkg.sv ====
`default_nettype none

package sv32_pkg;

    // --------------------
    // widths
    // --------------------
    // virtual and physical address widths for sv32
    localparam int unsigned VLEN     = 32;
    localparam int unsigned PLEN     = 34;
    localparam int unsigned PPN_W    = 22;
    // one vpn level, two levels in total
    localparam int unsigned VPN_W    = 10;
    localparam int unsigned PG_OFS_W = 12;

    // data tlb size and victim pointer width
    localparam int unsigned TLB_ENTRIES = 4;
    localparam int unsigned TLB_IDX_W   = $clog2(TLB_ENTRIES);

    // axi response code for a good read
    localparam logic [1:0] AXI_OKAY = 2'b00;

    // --------------------
    // exception causes
    // --------------------
    localparam logic [3:0] CAUSE_LD_ACCESS = 4'd5;
    localparam logic [3:0] CAUSE_ST_ACCESS = 4'd7;
    localparam logic [3:0] CAUSE_LD_PAGE   = 4'd13;
    localparam logic [3:0] CAUSE_ST_PAGE   = 4'd15;

    // --------------------
    // structs
    // --------------------
    // sv32 page table entry, msb first
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // refill from the walker or result of a lookup
    typedef struct packed {
        logic                 valid;
        logic [2*VPN_W-1:0]   vpn;
        logic                 is_4m;
        pte_t                 pte;
    } tlb_entry_t;

    // translation request from the load/store unit
    typedef struct packed {
        logic [VLEN-1:0] vaddr;
        logic            is_store;
    } lsu_req_t;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [VLEN-1:0] tval;
    } xlate_exc_t;

    typedef struct packed {
        logic [PLEN-1:0] paddr;
        xlate_exc_t      exc;
    } lsu_resp_t;

    // priv_user set means u-mode, clear means s-mode
    typedef struct packed {
        logic             en_translation;
        logic             priv_user;
        logic             sum;
        logic             mxr;
        logic [PPN_W-1:0] satp_ppn;
    } csr_cfg_t;

    // walker result
    // on an access fault the pte field carries bits 33:2 of the failing read address
    typedef struct packed {
        pte_t pte;
        logic is_4m;
        logic page_fault;
        logic access_fault;
    } walk_res_t;

    // axi4-lite read address and read data channels
    typedef struct packed {
        logic            arvalid;
        logic [PLEN-1:0] araddr;
    } axil_ar_t;

    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_r_t;

endpackage

`default_nettype wire

// ==== hw/sv32_tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sv32_tlb (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         flush_i,
    input  wire logic [sv32_pkg::VLEN-1:0]    lu_vaddr_i,
    output      logic                         lu_hit_o,
    output      sv32_pkg::tlb_entry_t         lu_entry_o,
    input  wire sv32_pkg::tlb_entry_t         update_i
);

    // entry payload, valid bits live apart
    sv32_pkg::tlb_entry_t entries_q [sv32_pkg::TLB_ENTRIES];
    logic [sv32_pkg::TLB_ENTRIES-1:0] valid_q;
    logic [sv32_pkg::TLB_ENTRIES-1:0] match;
    // next victim for a refill
    logic [sv32_pkg::TLB_IDX_W-1:0]   victim_q;

    // --------------------
    // lookup
    // --------------------
    always_comb begin : tag_match
        for (int i = 0; i < sv32_pkg::TLB_ENTRIES; i++) begin
            // vpn1 always compared
            match[i] = valid_q[i] && (entries_q[i].vpn[19:10] == lu_vaddr_i[31:22]);
            // vpn0 only for 4k pages, a megapage covers all of it
            if (!entries_q[i].is_4m && (entries_q[i].vpn[9:0] != lu_vaddr_i[21:12])) begin
                match[i] = 1'b0;
            end
        end
    end

    always_comb begin : hit_select
        lu_hit_o   = 1'b0;
        lu_entry_o = '0;
        // lowest matching index wins, duplicates hold the same translation
        for (int i = sv32_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                lu_hit_o         = 1'b1;
                lu_entry_o       = entries_q[i];
                lu_entry_o.valid = 1'b1;
            end
        end
    end

    // --------------------
    // refill and flush
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            // whole tlb goes, no asid or per-address flush
            valid_q  <= '0;
            victim_q <= '0;
        end else if (update_i.valid) begin
            valid_q[victim_q] <= 1'b1;
            // plain round robin
            if (victim_q == sv32_pkg::TLB_IDX_W'(sv32_pkg::TLB_ENTRIES - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    // payload write
    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            entries_q[victim_q] <= update_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sv32_ptw.sv ====
`timescale 1ns/10ps
`default_nettype none

module sv32_ptw (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire sv32_pkg::csr_cfg_t         csr_i,
    input  wire logic                       walk_req_i,
    input  wire logic [sv32_pkg::VLEN-1:0]  walk_vaddr_i,
    output      logic                       walk_done_o,
    output      sv32_pkg::walk_res_t        walk_res_o,
    output      sv32_pkg::tlb_entry_t       update_o,
    output      sv32_pkg::axil_ar_t         ar_o,
    input  wire logic                       arready_i,
    input  wire sv32_pkg::axil_r_t          r_i,
    output      logic                       rready_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_L1,
        S_L0
    } state_e;

    state_e state_q, state_d;
    logic arvalid_q, arvalid_d;
    logic [sv32_pkg::PLEN-1:0] addr_q, addr_d;
    // vaddr of the walk in progress
    logic [sv32_pkg::VLEN-1:0] vaddr_q;

    sv32_pkg::pte_t pte;
    logic r_fire;
    logic bus_err;
    logic pte_bad;
    logic is_ptr;

    // --------------------
    // axi read channel
    // --------------------
    assign ar_o.arvalid = arvalid_q;
    assign ar_o.araddr  = addr_q;
    // rready goes up once the address is taken and stays until rvalid
    assign rready_o     = (state_q != S_IDLE) && !arvalid_q;
    assign r_fire       = rready_o && r_i.rvalid;

    // pte decode
    assign pte     = r_i.rdata;
    assign bus_err = r_i.rresp != sv32_pkg::AXI_OKAY;
    assign pte_bad = !pte.v || (pte.w && !pte.r);
    assign is_ptr  = !pte.r && !pte.w && !pte.x;

    always_comb begin : walk_fsm
        state_d     = state_q;
        // hold arvalid until arready
        arvalid_d   = arvalid_q && !arready_i;
        addr_d      = addr_q;
        walk_done_o = 1'b0;
        walk_res_o  = '0;
        update_o    = '0;

        case (state_q)
            S_IDLE: begin
                if (walk_req_i) begin
                    state_d   = S_L1;
                    arvalid_d = 1'b1;
                    // satp.ppn * 4096 + vpn1 * 4
                    addr_d    = {csr_i.satp_ppn, walk_vaddr_i[31:22], 2'b00};
                end
            end
            S_L1, S_L0: begin
                if (r_fire) begin
                    walk_done_o      = 1'b1;
                    state_d          = S_IDLE;
                    walk_res_o.pte   = pte;
                    walk_res_o.is_4m = (state_q == S_L1);
                    if (bus_err) begin
                        // report the failing read address
                        walk_res_o.access_fault = 1'b1;
                        walk_res_o.pte = sv32_pkg::pte_t'(addr_q[sv32_pkg::PLEN-1:2]);
                    end else if (pte_bad) begin
                        walk_res_o.page_fault = 1'b1;
                    end else if (is_ptr) begin
                        if (state_q == S_L1) begin
                            // descend, pointer ppn * 4096 + vpn0 * 4
                            walk_done_o = 1'b0;
                            state_d     = S_L0;
                            arvalid_d   = 1'b1;
                            addr_d      = {pte.ppn1, pte.ppn0, vaddr_q[21:12], 2'b00};
                        end else begin
                            // no third level in sv32
                            walk_res_o.page_fault = 1'b1;
                        end
                    end else if ((state_q == S_L1) && (pte.ppn0 != '0)) begin
                        // misaligned megapage
                        walk_res_o.page_fault = 1'b1;
                    end else begin
                        // good leaf, refill in the same cycle
                        update_o.valid = 1'b1;
                        update_o.vpn   = vaddr_q[31:12];
                        update_o.is_4m = (state_q == S_L1);
                        update_o.pte   = pte;
                    end
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= S_IDLE;
            arvalid_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            arvalid_q <= arvalid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
        if ((state_q == S_IDLE) && walk_req_i) begin
            vaddr_q <= walk_vaddr_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sv32_lsu_xlate.sv ====
`timescale 1ns/10ps
`default_nettype none

module sv32_lsu_xlate (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire sv32_pkg::csr_cfg_t         csr_i,
    input  wire logic                       req_valid_i,
    input  wire sv32_pkg::lsu_req_t         req_i,
    output      logic                       req_ready_o,
    input  wire logic                       lu_hit_i,
    input  wire sv32_pkg::tlb_entry_t       lu_entry_i,
    output      logic                       walk_req_o,
    output      logic [sv32_pkg::VLEN-1:0]  walk_vaddr_o,
    input  wire logic                       walk_done_i,
    input  wire sv32_pkg::walk_res_t        walk_res_i,
    output      logic                       resp_valid_o,
    output      sv32_pkg::lsu_resp_t        resp_o
);

    // stage control
    logic valid_q;
    logic walk_pend_q;
    // stage payload, request plus lookup result
    sv32_pkg::lsu_req_t req_q;
    logic               hit_q;
    logic               is_4m_q;
    sv32_pkg::pte_t     pte_q;

    logic accept;
    logic miss;
    logic respond;
    sv32_pkg::pte_t leaf;
    logic leaf_4m;
    logic perm_err;
    logic [sv32_pkg::PLEN-1:0] paddr;

    // --------------------
    // handshake
    // --------------------
    // translating request without a tlb hit, stage stalls until the walk ends
    assign miss         = valid_q && csr_i.en_translation && !hit_q;
    assign req_ready_o  = !miss;
    assign accept       = req_valid_i && req_ready_o;
    // one pulse, walk_pend_q masks it afterwards
    assign walk_req_o   = miss && !walk_pend_q;
    assign walk_vaddr_o = req_q.vaddr;
    assign respond      = valid_q && (!miss || (walk_pend_q && walk_done_i));
    assign resp_valid_o = respond;

    // --------------------
    // leaf and paddr
    // --------------------
    // the walked leaf replaces the stored lookup on a miss
    assign leaf    = miss ? walk_res_i.pte : pte_q;
    assign leaf_4m = miss ? walk_res_i.is_4m : is_4m_q;

    always_comb begin : paddr_gen
        paddr = {leaf.ppn1, leaf.ppn0, req_q.vaddr[sv32_pkg::PG_OFS_W-1:0]};
        // megapage takes vpn0 straight from the vaddr
        if (leaf_4m) begin
            paddr[21:12] = req_q.vaddr[21:12];
        end
    end

    // privilege check, the walker does none
    assign perm_err = !leaf.a
                   || (!csr_i.priv_user && leaf.u && !csr_i.sum)
                   || (csr_i.priv_user && !leaf.u)
                   || (req_q.is_store && (!leaf.w || !leaf.d))
                   || (!req_q.is_store && !leaf.r && !(csr_i.mxr && leaf.x));

    always_comb begin : resp_gen
        // bare mode, zero-extended vaddr
        resp_o.paddr = {{(sv32_pkg::PLEN - sv32_pkg::VLEN){1'b0}}, req_q.vaddr};
        resp_o.exc   = '0;
        if (csr_i.en_translation) begin
            resp_o.paddr = paddr;
            if (miss && walk_res_i.access_fault) begin
                // bus error in the walk, tval is the pte address without bits 1:0
                resp_o.exc.valid = 1'b1;
                resp_o.exc.cause = req_q.is_store ? sv32_pkg::CAUSE_ST_ACCESS
                                                  : sv32_pkg::CAUSE_LD_ACCESS;
                resp_o.exc.tval  = walk_res_i.pte;
            end else if ((miss && walk_res_i.page_fault) || perm_err) begin
                resp_o.exc.valid = 1'b1;
                resp_o.exc.cause = req_q.is_store ? sv32_pkg::CAUSE_ST_PAGE
                                                  : sv32_pkg::CAUSE_LD_PAGE;
                resp_o.exc.tval  = req_q.vaddr;
            end
        end
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= 1'b0;
            walk_pend_q <= 1'b0;
        end else begin
            // a hit may leave and a new request enter in the same cycle
            valid_q     <= accept || (valid_q && !respond);
            walk_pend_q <= walk_req_o || (walk_pend_q && !walk_done_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q   <= req_i;
            hit_q   <= lu_hit_i;
            is_4m_q <= lu_entry_i.is_4m;
            pte_q   <= lu_entry_i.pte;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sv32_mmu.sv ====
`timescale 1ns/10ps
`default_nettype none

module sv32_mmu (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  flush_i,
    input  wire sv32_pkg::csr_cfg_t    csr_i,
    input  wire logic                  req_valid_i,
    input  wire sv32_pkg::lsu_req_t    req_i,
    output      logic                  req_ready_o,
    output      logic                  resp_valid_o,
    output      sv32_pkg::lsu_resp_t   resp_o,
    output      sv32_pkg::axil_ar_t    ar_o,
    input  wire logic                  arready_i,
    input  wire sv32_pkg::axil_r_t     r_i,
    output      logic                  rready_o
);

    // lookup side
    logic                      lu_hit;
    sv32_pkg::tlb_entry_t      lu_entry;
    // refill from the walker
    sv32_pkg::tlb_entry_t      update;
    // stage to walker
    logic                      walk_req;
    logic [sv32_pkg::VLEN-1:0] walk_vaddr;
    logic                      walk_done;
    sv32_pkg::walk_res_t       walk_res;

    // request stage, holds one request with its lookup result
    sv32_lsu_xlate u_lsu_xlate (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .csr_i        (csr_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .lu_hit_i     (lu_hit),
        .lu_entry_i   (lu_entry),
        .walk_req_o   (walk_req),
        .walk_vaddr_o (walk_vaddr),
        .walk_done_i  (walk_done),
        .walk_res_i   (walk_res),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

    // looked up with the incoming vaddr, result is registered by the stage
    sv32_tlb u_tlb (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .lu_vaddr_i (req_i.vaddr),
        .lu_hit_o   (lu_hit),
        .lu_entry_o (lu_entry),
        .update_i   (update)
    );

    sv32_ptw u_ptw (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .csr_i        (csr_i),
        .walk_req_i   (walk_req),
        .walk_vaddr_i (walk_vaddr),
        .walk_done_o  (walk_done),
        .walk_res_o   (walk_res),
        .update_o     (update),
        .ar_o         (ar_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rready_o     (rready_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_axil_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_axil_mem #(
    parameter logic [33:0] ERR_ADDR = 34'h0
) (
    input  wire logic                clk_i,
    input  wire sv32_pkg::axil_ar_t  ar_i,
    output      logic                arready_o,
    output      sv32_pkg::axil_r_t   r_o,
    input  wire logic                rready_i
);

    // sparse word storage, unmapped words read as zero (an invalid pte)
    logic [31:0] mem [logic [33:0]];
    logic [15:0] lfsr_q = 16'd5773;
    logic [33:0] addr;
    int          delay;

    task automatic write_word(input logic [33:0] a, input logic [31:0] d);
        mem[a] = d;
    endtask

    // galois lfsr, taps for a 16 bit maximal sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // two bits, one step per bit, gives 0 to 3 cycles
    task automatic draw_delay(output int d);
        lfsr_q = lfsr_next(lfsr_q);
        d      = int'(lfsr_q[0]);
        lfsr_q = lfsr_next(lfsr_q);
        d      = d * 2 + int'(lfsr_q[0]);
    endtask

    initial begin
        arready_o = 1'b0;
        r_o       = '0;
    end

    // ------------------------
    // one read at a time
    // ------------------------
    always begin
        @(negedge clk_i);
        if (ar_i.arvalid) begin
            draw_delay(delay);
            repeat (delay) @(posedge clk_i);
            @(posedge clk_i);
            #1;
            arready_o = 1'b1;
            addr      = ar_i.araddr;
            @(posedge clk_i);
            #1;
            arready_o = 1'b0;
            draw_delay(delay);
            repeat (delay) @(posedge clk_i);
            r_o.rvalid = 1'b1;
            r_o.rdata  = mem.exists(addr) ? mem[addr] : 32'h0;
            // slverr on the chosen address
            r_o.rresp  = (addr == ERR_ADDR) ? 2'b10 : 2'b00;
            do @(negedge clk_i); while (!rready_i);
            @(posedge clk_i);
            #1;
            r_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_sv32_mmu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sv32_mmu;

    typedef struct {
        string       name;
        logic [3:0]  mode;
        logic [31:0] vaddr;
        logic        is_store;
        logic        flush;
        int          lat_mode;
        logic [33:0] paddr;
        logic        exc_valid;
        logic [3:0]  cause;
        logic [31:0] tval;
    } row_t;

    // root table at 0x100000, slverr on the l1 entry of vpn1 6
    localparam logic [21:0] ROOT_PPN = 22'h100;
    localparam logic [33:0] ERR_ADDR = 34'h10_0018;

    logic clk = 1'b0;
    logic rst_n;
    logic flush;
    logic req_valid;
    logic req_ready;
    logic resp_valid;
    logic arready;
    logic rready;
    sv32_pkg::csr_cfg_t  csr;
    sv32_pkg::lsu_req_t  req;
    sv32_pkg::lsu_resp_t resp;
    sv32_pkg::axil_ar_t  ar;
    sv32_pkg::axil_r_t   r;
    row_t rows[$];
    int   errors = 0;
    int   checks = 0;

    always #2 clk = ~clk;

    sv32_mmu u_sv32_mmu (
        .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .csr_i(csr),
        .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
        .resp_valid_o(resp_valid), .resp_o(resp), .ar_o(ar),
        .arready_i(arready), .r_i(r), .rready_o(rready)
    );

    tb_axil_mem #(.ERR_ADDR(ERR_ADDR)) u_mem (
        .clk_i(clk), .ar_i(ar), .arready_o(arready),
        .r_o(r), .rready_i(rready)
    );

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic add_row(input string n, input logic [3:0] m, input logic [31:0] va,
                           input logic st, input logic fl, input int lat, input logic [33:0] pa,
                           input logic ev, input logic [3:0] c, input logic [31:0] tv);
        rows.push_back('{n, m, va, st, fl, lat, pa, ev, c, tv});
    endtask

    // mode bits are en, priv_user, sum, mxr
    task automatic run_row(input row_t t);
        int lat;
        if (t.flush) begin
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
        csr = '{t.mode[3], t.mode[2], t.mode[1], t.mode[0], ROOT_PPN};
        req.vaddr    = t.vaddr;
        req.is_store = t.is_store;
        req_valid    = 1'b1;
        // ready seen mid-cycle means accepted at the coming edge
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            // a walk holds off new requests until it answers
            if (!resp_valid) begin
                check({t.name, " ready"}, 0, req_ready);
            end
        end while (!resp_valid);
        check({t.name, " exc"}, t.exc_valid, resp.exc.valid);
        if (t.exc_valid) begin
            check({t.name, " cause"}, t.cause, resp.exc.cause);
            check({t.name, " tval"}, t.tval, resp.exc.tval);
        end else begin
            check({t.name, " paddr"}, t.paddr, resp.paddr);
        end
        if (t.lat_mode == 1) check({t.name, " latency"}, 1, lat);
        if (t.lat_mode == 2) check({t.name, " walked"}, 1, lat > 1);
        @(posedge clk);
        #1;
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin
        #1;
        #((rows.size() + 4) * 200);
        $display("timeout, the DUT stopped answering requests");
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        req = '0;
        csr = '{1'b0, 1'b0, 1'b0, 1'b0, ROOT_PPN};
        // l1 table, pointer, megapage, misaligned megapage
        u_mem.write_word(34'h10_0004, make_pte(22'h101, 8'h01));
        u_mem.write_word(34'h10_0008, make_pte({12'h123, 10'h0}, 8'hC7));
        u_mem.write_word(34'h10_000C, make_pte({12'h124, 10'h1}, 8'hC7));
        // l0 table, rw, read-only, dirty clear, user, execute-only
        u_mem.write_word(34'h10_1000, make_pte(22'h200, 8'hC7));
        u_mem.write_word(34'h10_1004, make_pte(22'h201, 8'hC3));
        u_mem.write_word(34'h10_1008, make_pte(22'h202, 8'h47));
        u_mem.write_word(34'h10_100C, make_pte(22'h203, 8'hD7));
        u_mem.write_word(34'h10_1010, make_pte(22'h204, 8'hC9));
        add_row("bypass", 4'b0000, 32'h8000_1234, 0, 0, 1, 34'h0_8000_1234, 0, 0, 0);
        add_row("4k_miss", 4'b1000, 32'h0040_0ABC, 0, 0, 2, 34'h20_0ABC, 0, 0, 0);
        add_row("4k_hit", 4'b1000, 32'h0040_0FF0, 1, 0, 1, 34'h20_0FF0, 0, 0, 0);
        add_row("mega", 4'b1000, 32'h0085_6789, 0, 0, 0, 34'h0_48C5_6789, 0, 0, 0);
        add_row("mega_misal", 4'b1000, 32'h00C0_0010, 0, 0, 0, 0, 1, 13, 32'h00C0_0010);
        add_row("st_ro", 4'b1000, 32'h0040_1000, 1, 0, 0, 0, 1, 15, 32'h0040_1000);
        add_row("st_dclr", 4'b1000, 32'h0040_2000, 1, 0, 0, 0, 1, 15, 32'h0040_2000);
        add_row("user_nosum", 4'b1000, 32'h0040_3004, 0, 0, 0, 0, 1, 13, 32'h0040_3004);
        add_row("user_sum", 4'b1010, 32'h0040_3004, 0, 0, 1, 34'h20_3004, 0, 0, 0);
        add_row("xo_nomxr", 4'b1000, 32'h0040_4008, 0, 0, 0, 0, 1, 13, 32'h0040_4008);
        add_row("xo_mxr", 4'b1001, 32'h0040_4008, 0, 0, 1, 34'h20_4008, 0, 0, 0);
        add_row("inv_l0", 4'b1000, 32'h0040_5000, 0, 0, 0, 0, 1, 13, 32'h0040_5000);
        add_row("inv_l1", 4'b1000, 32'h0100_0000, 0, 0, 0, 0, 1, 13, 32'h0100_0000);
        // tval is the failing pte address with bits 1:0 dropped
        add_row("slverr", 4'b1000, 32'h0180_0000, 0, 0, 0, 0, 1, 5, 32'(ERR_ADDR >> 2));
        // execute-only page still sits in the tlb from xo_mxr
        add_row("flush", 4'b1001, 32'h0040_4008, 0, 1, 2, 34'h20_4008, 0, 0, 0);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        foreach (rows[i]) run_row(rows[i]);
        // two back-to-back hits on the page refilled after the flush
        csr = '{1'b1, 1'b0, 1'b0, 1'b1, ROOT_PPN};
        req = '{32'h0040_4010, 1'b0};
        req_valid = 1'b1;
        @(negedge clk);
        check("stream_a ready", 1, req_ready);
        @(posedge clk);
        #1;
        req = '{32'h0040_4020, 1'b0};
        @(negedge clk);
        check("stream_b ready", 1, req_ready);
        check("stream_a resp", 1, resp_valid);
        check("stream_a exc", 0, resp.exc.valid);
        check("stream_a paddr", 34'h20_4010, resp.paddr);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        check("stream_b resp", 1, resp_valid);
        check("stream_b exc", 0, resp.exc.valid);
        check("stream_b paddr", 34'h20_4020, resp.paddr);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/sv32_pkg.sv
hw/sv32_tlb.sv
hw/sv32_ptw.sv
hw/sv32_lsu_xlate.sv
hw/sv32_mmu.sv
testbench/tb_axil_mem.sv
testbench/tb_sv32_mmu.sv

// ==== Makefile ====
TOP = tb_sv32_mmu
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
